// ==== list.f ====
src/fillq_pkg.sv
src/fillq_entry.sv
src/fillq.sv
src/fill_pipe.sv
src/l1_data_array.sv
src/l1_fill_top.sv
tb/l1_fill_tb.sv

// ==== tb/l1_fill_tb.sv ====
module l1_fill_tb;
    import fillq_pkg::*;

    logic         clk;
    logic         reset;
    logic         miss_valid;
    t_paddr       miss_addr;
    logic         fillq_full;
    logic         mem_req;
    t_mem_req     mem_req_pkt;
    logic         mem_gnt;
    t_mem_rsp     mem_rsp_pkt;
    logic         lookup_valid;
    t_paddr       lookup_addr;
    logic         lookup_hit;
    t_line        lookup_data;
    logic         fill_done;
    t_paddr       fill_addr;

    int unsigned  stim_seed = 58174;
    int unsigned  mem_seed = 58174;
    int           errors = 0;
    int           checks = 0;
    int           test_err_base = 0;
    int           tests_run = 0;
    int           tests_failed = 0;
    int           done_total = 0;
    int           outstanding [t_paddr];

    // Reference cache contents, per set
    logic                model_valid [NUM_SETS];
    logic [TAG_BITS-1:0] model_tag [NUM_SETS];
    t_line               model_line [NUM_SETS];
    logic                lu_pend;
    logic                lu_exp_hit;
    t_line               lu_exp_data;
    int                  fill_set;

    l1_fill_top l1_fill_top_i (
        .clk          (clk),
        .reset        (reset),
        .miss_valid   (miss_valid),
        .miss_addr    (miss_addr),
        .fillq_full   (fillq_full),
        .mem_req      (mem_req),
        .mem_req_pkt  (mem_req_pkt),
        .mem_gnt      (mem_gnt),
        .mem_rsp_pkt  (mem_rsp_pkt),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .lookup_hit   (lookup_hit),
        .lookup_data  (lookup_data),
        .fill_done    (fill_done),
        .fill_addr    (fill_addr)
    );

    function automatic int unsigned lcg_next(inout int unsigned state);
        state = state * 32'd1103515245 + 32'd12345;
        return state >> 16;
    endfunction

    // Memory contents, a hash of the line address
    function automatic t_line line_of(t_paddr addr);
        t_paddr base;
        t_line  x;
        base = addr & ~32'h7;
        x = {base, ~base};
        x = x * 64'd1103515245 + 64'd12345;
        return x;
    endfunction

    function automatic t_paddr make_addr(int unsigned tag, int unsigned index);
        t_paddr a;
        a = '0;
        a[ADDR_BITS-1 -: TAG_BITS] = TAG_BITS'(tag);
        a[OFFSET_BITS +: INDEX_BITS] = INDEX_BITS'(index);
        return a;
    endfunction

    // Expected {hit, data} of a lookup against the model
    function automatic logic [LINE_BITS:0] ref_lookup(t_paddr addr);
        int idx;
        idx = addr[OFFSET_BITS +: INDEX_BITS];
        if (model_valid[idx] && model_tag[idx] == addr[ADDR_BITS-1 -: TAG_BITS]) begin
            return {1'b1, model_line[idx]};
        end
        return {1'b0, {LINE_BITS{1'b0}}};
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory: grant after 0..3 cycles, answer after 2..12 cycles
    initial begin
        t_flq_id     pend_id [$];
        t_paddr      pend_addr [$];
        int          pend_due [$];
        int          gnt_wait;
        int          cycle;
        logic        found;
        mem_gnt = 1'b0;
        mem_rsp_pkt = '0;
        gnt_wait = -1;
        cycle = 0;
        forever begin
            @(posedge clk);
            #2;
            mem_gnt = 1'b0;
            mem_rsp_pkt = '0;
            if (reset) begin
                pend_id.delete();
                pend_addr.delete();
                pend_due.delete();
                gnt_wait = -1;
            end else begin
                if (mem_req) begin
                    if (gnt_wait < 0) begin
                        gnt_wait = lcg_next(mem_seed) % 4;
                    end
                    if (gnt_wait == 0) begin
                        checks++;
                        assert (outstanding.exists(mem_req_pkt.addr) &&
                                outstanding[mem_req_pkt.addr] > 0) else begin
                            $display("FAIL %0t: memory request for %h with no miss pending",
                                     $time, mem_req_pkt.addr);
                            errors++;
                        end
                        mem_gnt = 1'b1;
                        pend_id.push_back(mem_req_pkt.id);
                        pend_addr.push_back(mem_req_pkt.addr);
                        pend_due.push_back(cycle + 2 + int'(lcg_next(mem_seed) % 11));
                        gnt_wait = -1;
                    end else begin
                        gnt_wait--;
                    end
                end
                found = 1'b0;
                for (int i = 0; i < pend_due.size(); i++) begin
                    if (!found && pend_due[i] <= cycle) begin
                        found = 1'b1;
                        mem_rsp_pkt.valid = 1'b1;
                        mem_rsp_pkt.id = pend_id[i];
                        mem_rsp_pkt.data = line_of(pend_addr[i]);
                        pend_id.delete(i);
                        pend_addr.delete(i);
                        pend_due.delete(i);
                    end
                end
            end
            cycle++;
        end
    end

    // Compares lookups and fills against the model, mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            lu_pend = 1'b0;
            for (int i = 0; i < NUM_SETS; i++) begin
                model_valid[i] = 1'b0;
            end
        end else begin
            checks++;
            if (lu_pend) begin
                assert (lookup_hit == lu_exp_hit && (!lu_exp_hit || lookup_data == lu_exp_data))
                else begin
                    $display("FAIL %0t: lookup hit %b data %h, expected hit %b data %h",
                             $time, lookup_hit, lookup_data, lu_exp_hit, lu_exp_data);
                    errors++;
                end
            end else begin
                assert (!lookup_hit) else begin
                    $display("FAIL %0t: lookup_hit high without a lookup", $time);
                    errors++;
                end
            end
            lu_pend = lookup_valid;
            if (lookup_valid) begin
                {lu_exp_hit, lu_exp_data} = ref_lookup(lookup_addr);
            end
            if (fill_done) begin
                checks++;
                assert (outstanding.exists(fill_addr) && outstanding[fill_addr] > 0) else begin
                    $display("FAIL %0t: fill_done for %h with no miss left", $time, fill_addr);
                    errors++;
                end
                if (outstanding.exists(fill_addr)) begin
                    outstanding[fill_addr]--;
                end
                fill_set = fill_addr[OFFSET_BITS +: INDEX_BITS];
                model_valid[fill_set] = 1'b1;
                model_tag[fill_set] = fill_addr[ADDR_BITS-1 -: TAG_BITS];
                model_line[fill_set] = line_of(fill_addr);
                done_total++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic issue_miss(t_paddr addr);
        int n;
        n = 0;
        while (fillq_full && n < 500) begin
            next_cycle();
            n++;
        end
        assert (!fillq_full) else begin
            $display("timeout at %0t: fill queue stayed full", $time);
            errors++;
        end
        miss_valid = 1'b1;
        miss_addr = addr;
        if (outstanding.exists(addr)) begin
            outstanding[addr]++;
        end else begin
            outstanding[addr] = 1;
        end
        next_cycle();
        miss_valid = 1'b0;
    endtask

    task automatic wait_fills(int target, int limit);
        int n;
        n = 0;
        while (done_total < target && n < limit) begin
            next_cycle();
            n++;
        end
        assert (done_total >= target) else begin
            $display("timeout at %0t: %0d of %0d fills done", $time, done_total, target);
            errors++;
        end
    endtask

    task automatic lookup_expect(t_paddr addr, logic exp_hit);
        lookup_valid = 1'b1;
        lookup_addr = addr;
        next_cycle();
        lookup_valid = 1'b0;
        checks++;
        assert (lookup_hit == exp_hit && (!exp_hit || lookup_data == line_of(addr))) else begin
            $display("FAIL %0t: lookup %h gave hit %b data %h, expected hit %b",
                     $time, addr, lookup_hit, lookup_data, exp_hit);
            errors++;
        end
    endtask

    task automatic end_test(int num, string name);
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    initial begin
        int          base;
        int          n;
        int unsigned r;
        int unsigned tg;
        t_paddr      addrs [4];
        reset = 1'b1;
        miss_valid = 1'b0;
        miss_addr = '0;
        lookup_valid = 1'b0;
        lookup_addr = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();

        for (int i = 0; i < 4; i++) begin
            lookup_expect(make_addr(lcg_next(stim_seed), i * 3), 1'b0);
        end
        checks++;
        assert (!mem_req && !fillq_full) else begin
            $display("FAIL %0t: mem_req %b fillq_full %b while idle", $time, mem_req, fillq_full);
            errors++;
        end
        end_test(1, "lookups miss after reset");

        base = done_total;
        addrs[0] = make_addr(lcg_next(stim_seed), 5);
        issue_miss(addrs[0]);
        wait_fills(base + 1, 300);
        lookup_expect(addrs[0], 1'b1);
        repeat (20) next_cycle();
        checks++;
        assert (done_total == base + 1) else begin
            $display("FAIL %0t: %0d fills for a single miss", $time, done_total - base);
            errors++;
        end
        end_test(2, "single miss fills once");

        base = done_total;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = make_addr(lcg_next(stim_seed), 8 + i);
            issue_miss(addrs[i]);
        end
        wait_fills(base + 4, 600);
        for (int i = 0; i < 4; i++) begin
            lookup_expect(addrs[i], 1'b1);
        end
        end_test(3, "four outstanding misses");

        // Heavy lookup traffic steals the port from mm5
        base = done_total;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = make_addr(lcg_next(stim_seed), 12 + i);
            issue_miss(addrs[i]);
        end
        n = 0;
        while (done_total < base + 4 && n < 3000) begin
            r = lcg_next(stim_seed);
            lookup_valid = (r % 4) != 0;
            lookup_addr = addrs[(r >> 2) % 4];
            next_cycle();
            n++;
        end
        lookup_valid = 1'b0;
        assert (done_total >= base + 4) else begin
            $display("timeout at %0t: fills starved by lookups", $time);
            errors++;
        end
        for (int i = 0; i < 4; i++) begin
            lookup_expect(addrs[i], 1'b1);
        end
        end_test(4, "fills recycled under lookups");

        base = done_total;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = make_addr(lcg_next(stim_seed), i);
            issue_miss(addrs[i]);
        end
        checks++;
        assert (fillq_full) else begin
            $display("FAIL %0t: fillq_full low with four misses pending", $time);
            errors++;
        end
        wait_fills(base + 1, 300);
        checks++;
        assert (!fillq_full) else begin
            $display("FAIL %0t: fillq_full still high after a fill", $time);
            errors++;
        end
        wait_fills(base + 4, 600);
        end_test(5, "fill queue full flag");

        base = done_total;
        tg = lcg_next(stim_seed);
        addrs[0] = make_addr(tg, 6);
        addrs[1] = make_addr(tg ^ 1, 6);
        issue_miss(addrs[0]);
        wait_fills(base + 1, 300);
        issue_miss(addrs[1]);
        wait_fills(base + 2, 300);
        lookup_expect(addrs[0], 1'b0);
        lookup_expect(addrs[1], 1'b1);
        end_test(6, "same index replaces line");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src/l1_fill_top.sv ====
module l1_fill_top (
    input  logic                clk,
    input  logic                reset,

    input  logic                miss_valid,
    input  fillq_pkg::t_paddr   miss_addr,
    output logic                fillq_full,

    output logic                mem_req,
    output fillq_pkg::t_mem_req mem_req_pkt,
    input  logic                mem_gnt,
    input  fillq_pkg::t_mem_rsp mem_rsp_pkt,

    input  logic                lookup_valid,
    input  fillq_pkg::t_paddr   lookup_addr,
    output logic                lookup_hit,
    output fillq_pkg::t_line    lookup_data,

    output logic                fill_done,
    output fillq_pkg::t_paddr   fill_addr
);
    import fillq_pkg::*;

    logic         pipe_req_mm0;
    t_pipe_req    pipe_req_pkt_mm0;
    logic         pipe_valid_mm5;
    t_pipe_req    pipe_req_pkt_mm5;
    t_pipe_action pipe_action_mm5;
    logic         wr_en;
    t_paddr       wr_addr;
    t_line        wr_data;

    fillq fillq_i (
        .clk              (clk),
        .reset            (reset),
        .miss_valid       (miss_valid),
        .miss_addr        (miss_addr),
        .fillq_full       (fillq_full),
        .mem_req          (mem_req),
        .mem_req_pkt      (mem_req_pkt),
        .mem_gnt          (mem_gnt),
        .mem_rsp_pkt      (mem_rsp_pkt),
        .pipe_req_mm0     (pipe_req_mm0),
        .pipe_req_pkt_mm0 (pipe_req_pkt_mm0),
        .pipe_valid_mm5   (pipe_valid_mm5),
        .pipe_req_pkt_mm5 (pipe_req_pkt_mm5),
        .pipe_action_mm5  (pipe_action_mm5)
    );

    fill_pipe fill_pipe_i (
        .clk              (clk),
        .reset            (reset),
        .pipe_req_mm0     (pipe_req_mm0),
        .pipe_req_pkt_mm0 (pipe_req_pkt_mm0),
        .lookup_valid     (lookup_valid),
        .pipe_valid_mm5   (pipe_valid_mm5),
        .pipe_req_pkt_mm5 (pipe_req_pkt_mm5),
        .pipe_action_mm5  (pipe_action_mm5),
        .wr_en            (wr_en),
        .wr_addr          (wr_addr),
        .wr_data          (wr_data),
        .fill_done        (fill_done),
        .fill_addr        (fill_addr)
    );

    l1_data_array l1_data_array_i (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .lookup_valid (lookup_valid),
        .lookup_addr  (lookup_addr),
        .lookup_hit   (lookup_hit),
        .lookup_data  (lookup_data)
    );

endmodule

// ==== src/l1_data_array.sv ====
module l1_data_array (
    input  logic              clk,
    input  logic              reset,

    input  logic              wr_en,
    input  fillq_pkg::t_paddr wr_addr,
    input  fillq_pkg::t_line  wr_data,

    input  logic              lookup_valid,
    input  fillq_pkg::t_paddr lookup_addr,
    output logic              lookup_hit,
    output fillq_pkg::t_line  lookup_data
);
    import fillq_pkg::*;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        t_line               line;
    } t_array_set;

    logic [NUM_SETS-1:0]   set_valid;
    t_array_set            sets [NUM_SETS];
    logic [INDEX_BITS-1:0] wr_index;
    logic [TAG_BITS-1:0]   wr_tag;
    logic [INDEX_BITS-1:0] lu_index;
    logic [TAG_BITS-1:0]   lu_tag;
    t_array_set            lu_set;

    assign wr_index = wr_addr[OFFSET_BITS +: INDEX_BITS];
    assign wr_tag   = wr_addr[ADDR_BITS-1 -: TAG_BITS];
    assign lu_index = lookup_addr[OFFSET_BITS +: INDEX_BITS];
    assign lu_tag   = lookup_addr[ADDR_BITS-1 -: TAG_BITS];
    assign lu_set   = sets[lu_index];

    always_ff @(posedge clk) begin
        if (reset) begin
            set_valid <= '0;
        end else if (wr_en) begin
            set_valid[wr_index] <= 1'b1;
        end
    end

    // A fill replaces whatever the set held
    always_ff @(posedge clk) begin
        if (wr_en) begin
            sets[wr_index].tag  <= wr_tag;
            sets[wr_index].line <= wr_data;
        end
    end

    // Hit drops back to 0 on any cycle without a lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_hit <= 1'b0;
        end else begin
            lookup_hit <= lookup_valid && set_valid[lu_index] && (lu_set.tag == lu_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            lookup_data <= lu_set.line;
        end
    end

    // Single port, fills yield to lookups upstream
    a_port_conflict: assert property (
        @(posedge clk) disable iff (reset) !(wr_en && lookup_valid)
    );

endmodule

// ==== src/fill_pipe.sv ====
module fill_pipe (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    pipe_req_mm0,
    input  fillq_pkg::t_pipe_req    pipe_req_pkt_mm0,

    input  logic                    lookup_valid,

    output logic                    pipe_valid_mm5,
    output fillq_pkg::t_pipe_req    pipe_req_pkt_mm5,
    output fillq_pkg::t_pipe_action pipe_action_mm5,

    output logic                    wr_en,
    output fillq_pkg::t_paddr       wr_addr,
    output fillq_pkg::t_line        wr_data,

    output logic                    fill_done,
    output fillq_pkg::t_paddr       fill_addr
);
    import fillq_pkg::*;

    // Index 0 is mm0, index PIPE_DEPTH-1 is mm5
    logic [PIPE_DEPTH-1:0] valid_q;
    t_pipe_req             pkt_q [PIPE_DEPTH];
    logic                  complete_mm5;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[PIPE_DEPTH-2:0], pipe_req_mm0};
        end
    end

    always_ff @(posedge clk) begin
        pkt_q[0] <= pipe_req_pkt_mm0;
        for (int i = 1; i < PIPE_DEPTH; i++) begin
            pkt_q[i] <= pkt_q[i-1];
        end
    end

    assign pipe_valid_mm5   = valid_q[PIPE_DEPTH-1];
    assign pipe_req_pkt_mm5 = pkt_q[PIPE_DEPTH-1];

    // Lookup owns the array port this cycle
    assign complete_mm5             = pipe_valid_mm5 && !lookup_valid;
    assign pipe_action_mm5.complete = complete_mm5;
    assign pipe_action_mm5.recycle  = pipe_valid_mm5 && lookup_valid;

    assign wr_en   = complete_mm5;
    assign wr_addr = pipe_req_pkt_mm5.addr;
    assign wr_data = pipe_req_pkt_mm5.data;

    assign fill_done = complete_mm5;
    assign fill_addr = pipe_req_pkt_mm5.addr;

    a_action_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(pipe_action_mm5.complete && pipe_action_mm5.recycle) &&
        ((pipe_action_mm5.complete || pipe_action_mm5.recycle) == pipe_valid_mm5)
    );

endmodule

// ==== src/fillq.sv ====
module fillq (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    miss_valid,
    input  fillq_pkg::t_paddr       miss_addr,
    output logic                    fillq_full,

    output logic                    mem_req,
    output fillq_pkg::t_mem_req     mem_req_pkt,
    input  logic                    mem_gnt,
    input  fillq_pkg::t_mem_rsp     mem_rsp_pkt,

    output logic                    pipe_req_mm0,
    output fillq_pkg::t_pipe_req    pipe_req_pkt_mm0,

    input  logic                    pipe_valid_mm5,
    input  fillq_pkg::t_pipe_req    pipe_req_pkt_mm5,
    input  fillq_pkg::t_pipe_action pipe_action_mm5
);
    import fillq_pkg::*;

    logic [FLQ_ENTRIES-1:0] e_valid;
    logic [FLQ_ENTRIES-1:0] e_alloc;
    logic [FLQ_ENTRIES-1:0] e_mem_req;
    logic [FLQ_ENTRIES-1:0] e_mem_gnt;
    logic [FLQ_ENTRIES-1:0] e_pipe_req;
    logic [FLQ_ENTRIES-1:0] e_pipe_gnt;
    t_mem_req               e_mem_req_pkt [FLQ_ENTRIES];
    t_pipe_req              e_pipe_req_pkt [FLQ_ENTRIES];

    t_flq_static alloc_static;
    t_flq_id     alloc_id;
    logic        alloc_found;

    t_flq_id mem_ptr;
    t_flq_id mem_sel;
    t_flq_id mem_hold_id;
    logic    mem_hold;
    t_flq_id pipe_ptr;
    t_flq_id pipe_sel;

    // First requester at or after ptr, wrapping
    function automatic t_flq_id rr_pick(logic [FLQ_ENTRIES-1:0] req, t_flq_id ptr);
        t_flq_id idx;
        t_flq_id pick;
        pick = ptr;
        for (int i = FLQ_ENTRIES - 1; i >= 0; i--) begin
            idx = ptr + t_flq_id'(i);
            if (req[idx]) begin
                pick = idx;
            end
        end
        return pick;
    endfunction

    // Lowest free entry
    always_comb begin
        alloc_found = 1'b0;
        alloc_id    = '0;
        for (int i = 0; i < FLQ_ENTRIES; i++) begin
            if (!e_valid[i] && !alloc_found) begin
                alloc_found = 1'b1;
                alloc_id    = t_flq_id'(i);
            end
        end
    end

    assign alloc_static.paddr = miss_addr;
    assign fillq_full         = &e_valid;

    // Pick stays locked while a memory request waits for its grant
    assign mem_sel     = mem_hold ? mem_hold_id : rr_pick(e_mem_req, mem_ptr);
    assign mem_req     = |e_mem_req;
    assign mem_req_pkt = e_mem_req_pkt[mem_sel];

    // Pipeline never stalls, so any request is granted
    assign pipe_sel         = rr_pick(e_pipe_req, pipe_ptr);
    assign pipe_req_mm0     = |e_pipe_req;
    assign pipe_req_pkt_mm0 = e_pipe_req_pkt[pipe_sel];

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_hold <= 1'b0;
            mem_ptr  <= '0;
            pipe_ptr <= '0;
        end else begin
            mem_hold <= mem_req && !mem_gnt;
            if (mem_req && mem_gnt) begin
                mem_ptr <= mem_sel + 1'b1;
            end
            if (pipe_req_mm0) begin
                pipe_ptr <= pipe_sel + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_hold_id <= mem_sel;
    end

    for (genvar g = 0; g < FLQ_ENTRIES; g++) begin : g_entry
        assign e_alloc[g]    = miss_valid && alloc_found && (alloc_id == t_flq_id'(g));
        assign e_mem_gnt[g]  = mem_gnt && mem_req && (mem_sel == t_flq_id'(g));
        assign e_pipe_gnt[g] = pipe_req_mm0 && (pipe_sel == t_flq_id'(g));

        fillq_entry entry_i (
            .clk                (clk),
            .reset              (reset),
            .id                 (t_flq_id'(g)),
            .e_valid            (e_valid[g]),
            .e_mem_req          (e_mem_req[g]),
            .e_mem_req_pkt      (e_mem_req_pkt[g]),
            .e_mem_gnt          (e_mem_gnt[g]),
            .q_mem_rsp_pkt      (mem_rsp_pkt),
            .e_alloc            (e_alloc[g]),
            .q_alloc_static     (alloc_static),
            .e_pipe_req_mm0     (e_pipe_req[g]),
            .e_pipe_req_pkt_mm0 (e_pipe_req_pkt[g]),
            .e_pipe_gnt_mm0     (e_pipe_gnt[g]),
            .pipe_valid_mm5     (pipe_valid_mm5),
            .pipe_req_pkt_mm5   (pipe_req_pkt_mm5),
            .pipe_action_mm5    (pipe_action_mm5)
        );
    end

    a_miss_when_full: assert property (
        @(posedge clk) disable iff (reset) miss_valid |-> !fillq_full
    );

    a_gnt_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(e_mem_gnt) && $onehot0(e_pipe_gnt) &&
        ((e_mem_gnt & ~e_mem_req) == '0) && ((e_pipe_gnt & ~e_pipe_req) == '0)
    );

    // Request and packet hold until granted
    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_req && !mem_gnt |=> mem_req && $stable(mem_req_pkt)
    );

endmodule

// ==== src/fillq_entry.sv ====
module fillq_entry (
    input  logic                    clk,
    input  logic                    reset,
    input  fillq_pkg::t_flq_id      id,

    output logic                    e_valid,

    output logic                    e_mem_req,
    output fillq_pkg::t_mem_req     e_mem_req_pkt,
    input  logic                    e_mem_gnt,
    input  fillq_pkg::t_mem_rsp     q_mem_rsp_pkt,

    input  logic                    e_alloc,
    input  fillq_pkg::t_flq_static  q_alloc_static,

    output logic                    e_pipe_req_mm0,
    output fillq_pkg::t_pipe_req    e_pipe_req_pkt_mm0,
    input  logic                    e_pipe_gnt_mm0,

    input  logic                    pipe_valid_mm5,
    input  fillq_pkg::t_pipe_req    pipe_req_pkt_mm5,
    input  fillq_pkg::t_pipe_action pipe_action_mm5
);
    import fillq_pkg::*;

    typedef enum logic [2:0] {
        FLQ_IDLE,
        FLQ_PENDING,
        FLQ_REQ_MEM,
        FLQ_PDG_MEM,
        FLQ_REQ_PIPE,
        FLQ_PDG_PIPE,
        FLQ_WAIT
    } t_flq_fsm;

    t_flq_fsm    fsm;
    t_flq_fsm    fsm_nxt;
    t_flq_static e_static;
    t_line       e_line;
    logic        e_mem_rsp_valid;
    logic        e_action_valid_mm5;
    logic        e_complete_mm5;
    logic        e_recycle_mm5;

    assign e_mem_rsp_valid    = q_mem_rsp_pkt.valid && (q_mem_rsp_pkt.id == id);
    assign e_action_valid_mm5 = pipe_valid_mm5 && (pipe_req_pkt_mm5.id == id);
    assign e_complete_mm5     = e_action_valid_mm5 && pipe_action_mm5.complete;
    assign e_recycle_mm5      = e_action_valid_mm5 && pipe_action_mm5.recycle;

    always_comb begin
        fsm_nxt = fsm;
        unique case (fsm)
            FLQ_IDLE:     if (e_alloc) fsm_nxt = FLQ_PENDING;
            FLQ_PENDING:  fsm_nxt = FLQ_REQ_MEM;
            FLQ_REQ_MEM:  if (e_mem_gnt) fsm_nxt = FLQ_PDG_MEM;
            FLQ_PDG_MEM:  if (e_mem_rsp_valid) fsm_nxt = FLQ_REQ_PIPE;
            FLQ_REQ_PIPE: if (e_pipe_gnt_mm0) fsm_nxt = FLQ_PDG_PIPE;
            FLQ_PDG_PIPE: begin
                if (e_complete_mm5) begin
                    fsm_nxt = FLQ_IDLE;
                end else if (e_recycle_mm5) begin
                    fsm_nxt = FLQ_WAIT;
                end
            end
            FLQ_WAIT:     fsm_nxt = FLQ_REQ_PIPE;
            default:      fsm_nxt = FLQ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fsm <= FLQ_IDLE;
        end else begin
            fsm <= fsm_nxt;
        end
    end

    // Address at allocation, line on our response
    always_ff @(posedge clk) begin
        if (e_alloc) begin
            e_static <= q_alloc_static;
        end
        if (e_mem_rsp_valid) begin
            e_line <= q_mem_rsp_pkt.data;
        end
    end

    assign e_valid        = (fsm != FLQ_IDLE);
    assign e_mem_req      = (fsm == FLQ_REQ_MEM);
    assign e_pipe_req_mm0 = (fsm == FLQ_REQ_PIPE);

    always_comb begin
        e_mem_req_pkt.addr = e_static.paddr;
        e_mem_req_pkt.id   = id;
    end

    always_comb begin
        e_pipe_req_pkt_mm0.id   = id;
        e_pipe_req_pkt_mm0.addr = e_static.paddr;
        e_pipe_req_pkt_mm0.data = e_line;
    end

    a_alloc_when_valid: assert property (
        @(posedge clk) disable iff (reset) e_alloc |-> !e_valid
    );

    // memory answers only what this entry asked for
    a_rsp_when_pending: assert property (
        @(posedge clk) disable iff (reset) e_mem_rsp_valid |-> (fsm == FLQ_PDG_MEM)
    );

endmodule

// ==== src/fillq_pkg.sv ====
package fillq_pkg;

    // Address split
    localparam int ADDR_BITS   = 32;
    localparam int LINE_BITS   = 64;
    localparam int OFFSET_BITS = 3;
    localparam int INDEX_BITS  = 4;
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int NUM_SETS    = 1 << INDEX_BITS;

    // Fill queue and pipeline sizing
    localparam int FLQ_ENTRIES = 4;
    localparam int FLQ_ID_BITS = 2;
    localparam int PIPE_DEPTH  = 6;

    typedef logic [FLQ_ID_BITS-1:0] t_flq_id;

    // Offset bits of a line address are don't-care
    typedef logic [ADDR_BITS-1:0] t_paddr;

    typedef logic [LINE_BITS-1:0] t_line;

    // Captured when an entry is allocated
    typedef struct packed {
        t_paddr paddr;
    } t_flq_static;

    // Line request to memory
    typedef struct packed {
        t_paddr  addr;
        t_flq_id id;
    } t_mem_req;

    // Line response, routed back by id
    typedef struct packed {
        logic    valid;
        t_flq_id id;
        t_line   data;
    } t_mem_rsp;

    // Packet carried through mm0..mm5
    typedef struct packed {
        t_flq_id id;
        t_paddr  addr;
        t_line   data;
    } t_pipe_req;

    // Outcome at mm5
    typedef struct packed {
        logic complete;
        logic recycle;
    } t_pipe_action;

endpackage
